// File: hdl/sp605_ctrl_pkg.sv
package sp605_ctrl_pkg;

    localparam int APB_ADDR = 32;
    localparam int APB_DATA = 32;

    // Page map of 64 KB pages
    localparam int PAGE_LSB = 16;
    localparam int PAGE_W = APB_ADDR - PAGE_LSB;
    localparam int NUM_CHANNELS = 2;               // Works up to 8
    localparam int NUM_PAGES = NUM_CHANNELS + 1;
    localparam int PAGE_IRQ = 0;
    localparam int PAGE_CHAN0 = 1;

    // Channel register offsets
    localparam logic [PAGE_LSB-1:0] REG_ADDR = 16'h0000;
    localparam logic [PAGE_LSB-1:0] REG_LEN = 16'h0004;
    localparam logic [PAGE_LSB-1:0] REG_CTRL = 16'h0008;
    localparam logic [PAGE_LSB-1:0] REG_STATUS = 16'h000C;

    // Interrupt block offsets
    localparam logic [PAGE_LSB-1:0] REG_INT_STATUS = 16'h0000;
    localparam logic [PAGE_LSB-1:0] REG_INT_ENABLE = 16'h0004;

    localparam int LEN_W = 16;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_INTEN_BIT = 1;
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

    typedef struct packed {
        logic                sel;
        logic                enable;
        logic                write;
        logic [APB_ADDR-1:0] addr;
        logic [APB_DATA-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic                ready;
        logic [APB_DATA-1:0] rdata;
    } apb_rsp_t;

endpackage

// File: hdl/apb_page_decoder.sv
`timescale 1ns/10ps

module apb_page_decoder (
    input  sp605_ctrl_pkg::apb_req_t               req,
    output logic [sp605_ctrl_pkg::NUM_PAGES-1:0]   page_sel,
    output logic                                   null_sel
);

    logic [sp605_ctrl_pkg::PAGE_W-1:0] page;
    logic                              hit;

    // Page field sits above the 64 KB offset
    assign page = req.addr[sp605_ctrl_pkg::APB_ADDR-1:sp605_ctrl_pkg::PAGE_LSB];

    always_comb begin
        page_sel = '0;
        hit = 1'b0;
        if (req.sel) begin
            for (int i = 0; i < sp605_ctrl_pkg::NUM_PAGES; i++) begin
                if (page == sp605_ctrl_pkg::PAGE_W'(i)) begin
                    page_sel[i] = 1'b1;
                    hit = 1'b1;
                end
            end
        end
    end

    // Anything else goes to the null slave so the bus never hangs
    assign null_sel = req.sel && !hit;

endmodule

// File: hdl/dma_channel_ctrl.sv
`timescale 1ns/10ps

module dma_channel_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sp605_ctrl_pkg::apb_req_t req,
    input  logic                     sel,
    output sp605_ctrl_pkg::apb_rsp_t rsp,
    output logic                     int_out
);

    logic [sp605_ctrl_pkg::PAGE_LSB-1:0] offset;
    logic                                access;
    logic                                wr_en;
    logic                                start_go;

    logic [sp605_ctrl_pkg::APB_DATA-1:0] addr_reg;
    logic [sp605_ctrl_pkg::LEN_W-1:0]    len_reg;
    logic                                inten;

    logic [sp605_ctrl_pkg::LEN_W-1:0]    remaining;
    logic                                busy;
    logic                                done;

    logic [sp605_ctrl_pkg::APB_DATA-1:0] rdata_mux;

    assign offset = req.addr[sp605_ctrl_pkg::PAGE_LSB-1:0];
    assign access = sel && req.enable;      // Zero wait states
    assign wr_en = access && req.write;

    // Start is ignored while a countdown runs
    assign start_go = wr_en && (offset == sp605_ctrl_pkg::REG_CTRL) &&
                      req.wdata[sp605_ctrl_pkg::CTRL_START_BIT] && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_reg <= '0;
            len_reg <= '0;
            inten <= 1'b0;
            remaining <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (wr_en) begin
                case (offset)
                    sp605_ctrl_pkg::REG_ADDR: addr_reg <= req.wdata;
                    sp605_ctrl_pkg::REG_LEN: len_reg <= req.wdata[sp605_ctrl_pkg::LEN_W-1:0];
                    sp605_ctrl_pkg::REG_CTRL: inten <= req.wdata[sp605_ctrl_pkg::CTRL_INTEN_BIT];
                    sp605_ctrl_pkg::REG_STATUS: begin
                        if (req.wdata[sp605_ctrl_pkg::STAT_DONE_BIT]) begin
                            done <= 1'b0;       // Write 1 to clear
                        end
                    end
                    default: ;
                endcase
            end

            if (start_go) begin
                remaining <= len_reg;
                if (len_reg == '0) begin
                    done <= 1'b1;               // Empty transfer completes at once
                end else begin
                    busy <= 1'b1;
                    done <= 1'b0;
                end
            end

            // One word per cycle so busy lasts exactly LEN cycles
            if (busy) begin
                remaining <= remaining - sp605_ctrl_pkg::LEN_W'(1);
                if (remaining == sp605_ctrl_pkg::LEN_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        rdata_mux = '0;
        case (offset)
            sp605_ctrl_pkg::REG_ADDR: rdata_mux = addr_reg;
            sp605_ctrl_pkg::REG_LEN: rdata_mux[sp605_ctrl_pkg::LEN_W-1:0] = len_reg;
            sp605_ctrl_pkg::REG_CTRL: rdata_mux[sp605_ctrl_pkg::CTRL_INTEN_BIT] = inten;
            sp605_ctrl_pkg::REG_STATUS: begin
                rdata_mux[sp605_ctrl_pkg::STAT_BUSY_BIT] = busy;
                rdata_mux[sp605_ctrl_pkg::STAT_DONE_BIT] = done;
                rdata_mux[sp605_ctrl_pkg::APB_DATA-1 -: sp605_ctrl_pkg::LEN_W] = remaining;
            end
            default: ;                          // Undefined offsets read 0
        endcase
    end

    // Unselected slave stays silent so the merge can OR responses
    assign rsp.ready = access;
    assign rsp.rdata = (access && !req.write) ? rdata_mux : '0;

    // Registered in the interrupt block
    assign int_out = done && inten;

endmodule

// File: hdl/apb_response_irq_merge.sv
`timescale 1ns/10ps

module apb_response_irq_merge (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  sp605_ctrl_pkg::apb_req_t              req,
    input  logic                                  irq_sel,
    input  logic                                  null_sel,
    input  sp605_ctrl_pkg::apb_rsp_t              chan_rsp [sp605_ctrl_pkg::NUM_CHANNELS],
    input  logic [sp605_ctrl_pkg::NUM_CHANNELS-1:0] chan_int,
    output sp605_ctrl_pkg::apb_rsp_t              rsp,
    output logic                                  irq
);

    logic [sp605_ctrl_pkg::PAGE_LSB-1:0]     offset;
    logic                                    irq_ready;
    logic                                    null_ready;
    logic [sp605_ctrl_pkg::APB_DATA-1:0]     irq_rdata;
    logic [sp605_ctrl_pkg::NUM_CHANNELS-1:0] int_enable;

    assign offset = req.addr[sp605_ctrl_pkg::PAGE_LSB-1:0];
    assign irq_ready = irq_sel && req.enable;
    assign null_ready = null_sel && req.enable;  // Null slave returns 0 data

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_enable <= '0;
            irq <= 1'b0;
        end else begin
            if (irq_ready && req.write && offset == sp605_ctrl_pkg::REG_INT_ENABLE) begin
                int_enable <= req.wdata[sp605_ctrl_pkg::NUM_CHANNELS-1:0];
            end
            irq <= |(chan_int & int_enable);
        end
    end

    // INT_STATUS is a live view of the channel lines
    always_comb begin
        irq_rdata = '0;
        if (irq_ready && !req.write) begin
            case (offset)
                sp605_ctrl_pkg::REG_INT_STATUS:
                    irq_rdata[sp605_ctrl_pkg::NUM_CHANNELS-1:0] = chan_int;
                sp605_ctrl_pkg::REG_INT_ENABLE:
                    irq_rdata[sp605_ctrl_pkg::NUM_CHANNELS-1:0] = int_enable;
                default: ;
            endcase
        end
    end

    // Only the selected slave drives, so a plain OR merges them
    always_comb begin
        rsp.ready = irq_ready || null_ready;
        rsp.rdata = irq_rdata;
        for (int i = 0; i < sp605_ctrl_pkg::NUM_CHANNELS; i++) begin
            rsp.ready = rsp.ready || chan_rsp[i].ready;
            rsp.rdata = rsp.rdata | chan_rsp[i].rdata;
        end
    end

endmodule

// File: hdl/sp605_ctrl_core.sv
`timescale 1ns/10ps

module sp605_ctrl_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sp605_ctrl_pkg::apb_req_t req,
    output sp605_ctrl_pkg::apb_rsp_t rsp,
    output logic                     irq
);

    logic [sp605_ctrl_pkg::NUM_PAGES-1:0]    page_sel;
    logic                                    null_sel;
    sp605_ctrl_pkg::apb_rsp_t                chan_rsp [sp605_ctrl_pkg::NUM_CHANNELS];
    logic [sp605_ctrl_pkg::NUM_CHANNELS-1:0] chan_int;

    apb_page_decoder u_decoder (
        .req      (req),
        .page_sel (page_sel),
        .null_sel (null_sel)
    );

    // One controller per page above the interrupt block
    for (genvar i = 0; i < sp605_ctrl_pkg::NUM_CHANNELS; i++) begin : g_chan
        dma_channel_ctrl u_chan (
            .clk     (clk),
            .rst_n   (rst_n),
            .req     (req),
            .sel     (page_sel[sp605_ctrl_pkg::PAGE_CHAN0+i]),
            .rsp     (chan_rsp[i]),
            .int_out (chan_int[i])
        );
    end

    apb_response_irq_merge u_merge (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .irq_sel  (page_sel[sp605_ctrl_pkg::PAGE_IRQ]),
        .null_sel (null_sel),
        .chan_rsp (chan_rsp),
        .chan_int (chan_int),
        .rsp      (rsp),
        .irq      (irq)
    );

endmodule

// File: verification/sp605_ctrl_core_assert.sv
`timescale 1ns/10ps

module sp605_ctrl_core_assert (
    input logic                                    clk,
    input logic                                    rst_n,
    input sp605_ctrl_pkg::apb_req_t                req,
    input sp605_ctrl_pkg::apb_rsp_t                rsp,
    input sp605_ctrl_pkg::apb_rsp_t                chan_rsp [sp605_ctrl_pkg::NUM_CHANNELS],
    input logic [sp605_ctrl_pkg::NUM_CHANNELS-1:0] chan_int,
    input logic [sp605_ctrl_pkg::NUM_CHANNELS-1:0] int_enable,
    input logic                                    irq
);

    logic [sp605_ctrl_pkg::PAGE_W-1:0] page;

    assign page = req.addr[sp605_ctrl_pkg::APB_ADDR-1:sp605_ctrl_pkg::PAGE_LSB];

    ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.ready |-> (req.sel && req.enable))
        else $error("ready seen outside an APB access cycle");

    // irq is one flop behind the masked status
    irq_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> $past(|(chan_int & int_enable)))
        else $error("irq high without an enabled channel interrupt");

    for (genvar i = 0; i < sp605_ctrl_pkg::NUM_CHANNELS; i++) begin : g_chan
        chan_ready_selected: assert property (@(posedge clk) disable iff (!rst_n)
            chan_rsp[i].ready |->
                (req.sel && page == sp605_ctrl_pkg::PAGE_W'(sp605_ctrl_pkg::PAGE_CHAN0 + i)))
            else $error("channel %0d ready while not selected", i);
    end

endmodule

bind apb_response_irq_merge sp605_ctrl_core_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .rsp        (rsp),
    .chan_rsp   (chan_rsp),
    .chan_int   (chan_int),
    .int_enable (int_enable),
    .irq        (irq)
);

// File: verification/sp605_ctrl_core_tb.sv
`timescale 1ns/10ps

module sp605_ctrl_core_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY = 2;
    localparam int RESET_CYCLES = 4;
    localparam int READY_LIMIT = 8;
    localparam int POLL_LIMIT = 64;
    localparam int CYCLE_LIMIT = 4000;     // About 60 steps of 3 cycles plus the countdowns

    localparam int CH0 = sp605_ctrl_pkg::PAGE_CHAN0;
    localparam int CH1 = sp605_ctrl_pkg::PAGE_CHAN0 + 1;
    localparam int IRQ_PG = sp605_ctrl_pkg::PAGE_IRQ;

    localparam logic [31:0] ST_DONE = 32'h1 << sp605_ctrl_pkg::STAT_DONE_BIT;
    localparam logic [31:0] CT_START = 32'h1 << sp605_ctrl_pkg::CTRL_START_BIT;
    localparam logic [31:0] CT_INTEN = 32'h1 << sp605_ctrl_pkg::CTRL_INTEN_BIT;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_BUSY,    // STATUS busy with remaining in 1..exp
        OP_DONE,    // Poll STATUS until busy clears
        OP_IRQ      // irq level after the next edge
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic                     clk;
    logic                     rst_n;
    sp605_ctrl_pkg::apb_req_t req;
    sp605_ctrl_pkg::apb_rsp_t rsp;
    logic                     irq;

    step_t steps [$];
    int    cycles = 0;

    sp605_ctrl_core dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp),
        .irq   (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout after %0d cycles, the test never finished", cycles));
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Fail at %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] page_addr(input int page, input logic [15:0] offset);
        return {sp605_ctrl_pkg::PAGE_W'(page), offset};
    endfunction

    function automatic step_t make_step(input op_t op, input logic [31:0] addr,
                                        input logic [31:0] data, input logic [31:0] exp);
        return step_t'{op, addr, data, exp};
    endfunction

    // Setup cycle, then access cycle held until ready
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int   waits;
        logic got;
        waits = 0;
        got = 1'b0;
        rdata = '0;
        @(posedge clk);
        #DRIVE_DLY;
        req.sel = 1'b1;
        req.enable = 1'b0;
        req.write = write;
        req.addr = addr;
        req.wdata = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        req.enable = 1'b1;
        while (!got) begin
            @(negedge clk);                 // Response settled by mid-cycle
            if (rsp.ready) begin
                got = 1'b1;
                rdata = rsp.rdata;
            end else if (waits >= READY_LIMIT) begin
                fail_run($sformatf("No ready from the slave at address 0x%08h", addr));
            end else begin
                waits++;
                @(posedge clk);
            end
        end
        // Ready belongs in the first access cycle
        check_value("rsp.ready wait states", 32'(waits), 32'h0);
        @(posedge clk);
        #DRIVE_DLY;
        req = '0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        apb_transfer(1'b1, addr, data, ignored);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_done(input logic [31:0] addr, output logic [31:0] status);
        int polls;
        polls = 0;
        apb_read(addr, status);
        while (status[sp605_ctrl_pkg::STAT_BUSY_BIT]) begin
            if (polls >= POLL_LIMIT) begin
                fail_run($sformatf("Channel at 0x%08h stayed busy too long", addr));
            end else begin
                polls++;
                apb_read(addr, status);
            end
        end
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rd;
        logic [15:0] rem;
        string       where;
        where = $sformatf("rsp.rdata @ 0x%08h", s.addr);
        case (s.op)
            OP_WR: apb_write(s.addr, s.data);
            OP_RD: begin
                apb_read(s.addr, rd);
                check_value(where, rd, s.exp);
            end
            OP_BUSY: begin
                apb_read(s.addr, rd);
                rem = rd[31:16];
                check_value("status busy", 32'(rd[sp605_ctrl_pkg::STAT_BUSY_BIT]), 32'h1);
                check_value($sformatf("status remaining %0d within 1..%0d", rem, s.exp),
                            32'(rem != 0 && rem <= s.exp[15:0]), 32'h1);
            end
            OP_DONE: begin
                wait_done(s.addr, rd);
                check_value(where, rd, s.exp);
            end
            OP_IRQ: begin
                @(posedge clk);
                @(negedge clk);
                check_value("irq", 32'(irq), s.exp);
            end
            default: fail_run("Unknown step kind in the stimulus table");
        endcase
    endtask

    task automatic build_table();
        logic [31:0] a [2];
        logic [31:0] l [2];
        logic [31:0] n0;
        logic [31:0] n1;
        logic [31:0] n2;
        int          far_page;
        for (int c = 0; c < 2; c++) begin
            a[c] = $urandom;
            l[c] = $urandom & 32'hFFFF;
        end
        n0 = 16 + $urandom % 32;
        n1 = 16 + $urandom % 32;
        n2 = 16 + $urandom % 32;
        far_page = sp605_ctrl_pkg::NUM_PAGES + int'($urandom % (65536 - sp605_ctrl_pkg::NUM_PAGES));

        // Reset values
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH1, sp605_ctrl_pkg::REG_ADDR), 0, 0));
        steps.push_back(make_step(OP_RD, page_addr(IRQ_PG, sp605_ctrl_pkg::REG_INT_ENABLE), 0, 0));

        for (int c = 0; c < 2; c++) begin
            steps.push_back(make_step(OP_WR, page_addr(CH0 + c, sp605_ctrl_pkg::REG_ADDR), a[c], 0));
            steps.push_back(make_step(OP_WR, page_addr(CH0 + c, sp605_ctrl_pkg::REG_LEN), l[c], 0));
            steps.push_back(make_step(OP_WR, page_addr(CH0 + c, sp605_ctrl_pkg::REG_CTRL),
                                      CT_INTEN, 0));
        end
        for (int c = 0; c < 2; c++) begin
            steps.push_back(make_step(OP_RD, page_addr(CH0 + c, sp605_ctrl_pkg::REG_ADDR), 0, a[c]));
            steps.push_back(make_step(OP_RD, page_addr(CH0 + c, sp605_ctrl_pkg::REG_LEN), 0, l[c]));
            steps.push_back(make_step(OP_RD, page_addr(CH0 + c, sp605_ctrl_pkg::REG_CTRL),
                                      0, CT_INTEN));
        end
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), 0, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), 0, 0));

        // Pages without a slave
        steps.push_back(make_step(OP_RD, page_addr(sp605_ctrl_pkg::NUM_PAGES, 16'h0), 0, 0));
        steps.push_back(make_step(OP_RD, page_addr(far_page, sp605_ctrl_pkg::REG_STATUS), 0, 0));
        steps.push_back(make_step(OP_WR, page_addr(far_page, sp605_ctrl_pkg::REG_ADDR), $urandom, 0));
        steps.push_back(make_step(OP_WR, page_addr(sp605_ctrl_pkg::NUM_PAGES, 16'h4), 32'hFF, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_ADDR), 0, a[0]));
        steps.push_back(make_step(OP_RD, page_addr(CH1, sp605_ctrl_pkg::REG_LEN), 0, l[1]));
        steps.push_back(make_step(OP_RD, page_addr(IRQ_PG, sp605_ctrl_pkg::REG_INT_ENABLE), 0, 0));

        // Countdown, then write 1 to clear done
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_LEN), n0, 0));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), CT_START, 0));
        steps.push_back(make_step(OP_BUSY, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, n0));
        steps.push_back(make_step(OP_DONE, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, ST_DONE));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), ST_DONE, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, 0));

        // Zero length finishes without busy
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_LEN), 0, 0));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), CT_START, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, ST_DONE));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), ST_DONE, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, 0));

        // Second start while busy must not reload the count
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_LEN), n1, 0));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), CT_START, 0));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_LEN), n1 + 100, 0));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), CT_START, 0));
        steps.push_back(make_step(OP_BUSY, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, n1));
        steps.push_back(make_step(OP_DONE, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, ST_DONE));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_LEN), 0, n1 + 100));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), ST_DONE, 0));

        // Interrupt path through page 0
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_LEN), n2, 0));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL),
                                  CT_START | CT_INTEN, 0));
        steps.push_back(make_step(OP_DONE, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), 0, ST_DONE));
        steps.push_back(make_step(OP_RD, page_addr(IRQ_PG, sp605_ctrl_pkg::REG_INT_STATUS), 0, 1));
        steps.push_back(make_step(OP_IRQ, 0, 0, 0));    // Masked while INT_ENABLE is clear
        steps.push_back(make_step(OP_WR, page_addr(IRQ_PG, sp605_ctrl_pkg::REG_INT_ENABLE), 1, 0));
        steps.push_back(make_step(OP_IRQ, 0, 0, 1));
        steps.push_back(make_step(OP_RD, page_addr(IRQ_PG, sp605_ctrl_pkg::REG_INT_ENABLE), 0, 1));
        steps.push_back(make_step(OP_WR, page_addr(CH0, sp605_ctrl_pkg::REG_STATUS), ST_DONE, 0));
        steps.push_back(make_step(OP_IRQ, 0, 0, 0));
        steps.push_back(make_step(OP_RD, page_addr(IRQ_PG, sp605_ctrl_pkg::REG_INT_STATUS), 0, 0));
        steps.push_back(make_step(OP_RD, page_addr(CH0, sp605_ctrl_pkg::REG_CTRL), 0, CT_INTEN));

        // Channel 1 untouched by all of the above
        steps.push_back(make_step(OP_RD, page_addr(CH1, sp605_ctrl_pkg::REG_ADDR), 0, a[1]));
        steps.push_back(make_step(OP_RD, page_addr(CH1, sp605_ctrl_pkg::REG_LEN), 0, l[1]));
        steps.push_back(make_step(OP_RD, page_addr(CH1, sp605_ctrl_pkg::REG_CTRL), 0, CT_INTEN));
        steps.push_back(make_step(OP_RD, page_addr(CH1, sp605_ctrl_pkg::REG_STATUS), 0, 0));
    endtask

    initial begin
        req = '0;
        rst_n = 1'b0;
        void'($urandom(32'ha05d));
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: list.f
hdl/sp605_ctrl_pkg.sv
hdl/apb_page_decoder.sv
hdl/dma_channel_ctrl.sv
hdl/apb_response_irq_merge.sv
hdl/sp605_ctrl_core.sv
verification/sp605_ctrl_core_assert.sv
verification/sp605_ctrl_core_tb.sv

// File: Makefile
TOP = sp605_ctrl_core_tb
SRCS = $(wildcard hdl/*.sv) $(wildcard verification/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

obj_dir/V$(TOP): list.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

# A $fatal in the run gives a non-zero exit status, so make fails too
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
